// ==== project.f ====
+incdir+sim
src/trit_pkg.sv
src/alu_op_pkg.sv
src/trit_logic_unit.sv
src/trit_arith_unit.sv
src/alu_result_stage.sv
src/ternary_alu.sv
sim/tb_ternary_alu.sv

// ==== sim/tb_ternary_model.svh ====
// Reference model: trit values, word to integer and back, expected result per opcode

// Trit code to -1, 0 or +1
function automatic int trit_value(input trit_pkg::trit_t t);
    case (t)
        trit_pkg::TRIT_NEG: return -1;
        trit_pkg::TRIT_POS: return 1;
        // Illegal code counts as zero
        default: return 0;
    endcase
endfunction

// Digit -1, 0 or +1 to trit code
function automatic trit_pkg::trit_t trit_code(input int d);
    case (d)
        -1: return trit_pkg::TRIT_NEG;
        1: return trit_pkg::TRIT_POS;
        default: return trit_pkg::TRIT_ZERO;
    endcase
endfunction

// Most significant trit first
function automatic int word_value(input trit_pkg::word_t w);
    int v;
    v = 0;
    for (int i = trit_pkg::WORD_TRITS - 1; i >= 0; i--)
        v = v * 3 + trit_value(w[i]);
    return v;
endfunction

// Nine balanced digits keep v modulo 3^9, so the word lands in -9841..9841
function automatic trit_pkg::word_t int_to_word(input int v);
    trit_pkg::word_t w;
    int r;
    for (int i = 0; i < trit_pkg::WORD_TRITS; i++) begin
        // Balanced remainder in -1..1
        r = ((v + 1) % 3 + 3) % 3 - 1;
        w[i] = trit_code(r);
        v = (v - r) / 3;
    end
    return w;
endfunction

// Expected ALU result from the opcode rules
function automatic trit_pkg::word_t expected_result(
    input alu_op_pkg::opcode_u op,
    input trit_pkg::word_t x,
    input trit_pkg::word_t y
);
    trit_pkg::word_t w;
    int unit;
    int sel;
    int p;
    int q;
    int r;
    unit = trit_value(op.field.unit);
    // Function index 0..3, -1 for codes outside the table
    sel = -1;
    if (op.field.fn[1] inside {trit_pkg::TRIT_ZERO, trit_pkg::TRIT_POS} &&
        op.field.fn[0] inside {trit_pkg::TRIT_ZERO, trit_pkg::TRIT_POS})
        sel = 2 * trit_value(op.field.fn[1]) + trit_value(op.field.fn[0]);
    if (unit == 0 || sel < 0)
        return x;
    p = word_value(x);
    q = word_value(y);
    if (unit > 0) begin
        case (sel)
            0: return int_to_word(p + q);
            1: return int_to_word(p - q);
            2: return int_to_word((p < q) ? 1 : 0);
            default: return int_to_word((p == q) ? 1 : 0);
        endcase
    end
    for (int i = 0; i < trit_pkg::WORD_TRITS; i++) begin
        p = trit_value(x[i]);
        q = trit_value(y[i]);
        case (sel)
            0: r = -p;
            1: r = (p < q) ? p : q;
            2: r = (p > q) ? p : q;
            // XOR passes the other input when one is zero
            // Equal nonzero trits give -1 and opposite ones give 0
            default: r = (p == 0) ? q : (q == 0) ? p : (p == q) ? -1 : 0;
        endcase
        w[i] = trit_code(r);
    end
    return w;
endfunction

// ==== sim/tb_ternary_alu.sv ====
// Ternary ALU testbench: clock, reset, req/ack driver, directed tests, LFSR operands, timeout
`timescale 1ns/10ps

module tb_ternary_alu;

    // Run limit from about 270 transactions of at most 6 cycles each, plus reset
    localparam int MAX_OPS = 300;
    localparam int OP_CYCLES = 6;
    localparam int TIMEOUT_CYCLES = MAX_OPS * OP_CYCLES + 200;
    localparam logic [31:0] LFSR_SEED = 32'hd9af;

    logic                clock;
    logic                arst_n;
    logic                req;
    alu_op_pkg::opcode_u opcode;
    trit_pkg::word_t     a;
    trit_pkg::word_t     b;
    logic                ack;
    trit_pkg::word_t     result;

    int          errors;
    int          checks;
    int          cycle_count;
    // Cycles spent waiting for ack high and for ack low in the last transaction
    int          rise_cycles;
    int          fall_cycles;
    logic [31:0] lfsr;

    `include "tb_ternary_model.svh"

    ternary_alu u_dut (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (req),
        .opcode (opcode),
        .a      (a),
        .b      (b),
        .ack    (ack),
        .result (result)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the ALU did not answer within %0d cycles", TIMEOUT_CYCLES);
            $display("%0d checks, %0d errors", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // Two bits per trit with code 2'b10 drawn again
    function automatic trit_pkg::word_t random_word();
        trit_pkg::word_t w;
        trit_pkg::trit_t t;
        for (int i = 0; i < trit_pkg::WORD_TRITS; i++) begin
            do begin
                t[1] = lfsr_bit();
                t[0] = lfsr_bit();
            end while (t == 2'b10);
            w[i] = t;
        end
        return w;
    endfunction

    function automatic alu_op_pkg::opcode_u make_op(
        input trit_pkg::trit_t unit,
        input alu_op_pkg::fn_t fn
    );
        alu_op_pkg::opcode_u op;
        op.field.unit = unit;
        op.field.fn = fn;
        return op;
    endfunction

    // One four-phase transaction entered and left 1 ns after an edge
    task automatic do_op(
        input alu_op_pkg::opcode_u op,
        input trit_pkg::word_t x,
        input trit_pkg::word_t y,
        input string name
    );
        trit_pkg::word_t expected;
        trit_pkg::word_t sampled;
        expected = expected_result(op, x, y);
        opcode = op;
        a = x;
        b = y;
        req = 1'b1;
        rise_cycles = 0;
        fall_cycles = 0;
        do begin
            @(posedge clock);
            #1;
            rise_cycles++;
        end while (!ack);
        sampled = result;
        req = 1'b0;
        do begin
            @(posedge clock);
            #1;
            fall_cycles++;
        end while (ack);
        checks++;
        assert (sampled === expected) else begin
            errors++;
            $display("error %0t: %s a=%h b=%h expected %h got %h",
                     $time, name, x, y, expected, sampled);
        end
    endtask

    task automatic reset_and_timing();
        checks++;
        assert (ack === 1'b0 && result === '0) else begin
            errors++;
            $display("error %0t: after reset ack=%b result=%h", $time, ack, result);
        end
        do_op(make_op(alu_op_pkg::UNIT_ARITH, alu_op_pkg::FN_0),
              random_word(), random_word(), "ADD");
        // Ack one cycle after req is seen high, and again after req is seen low
        checks++;
        assert (rise_cycles == 1 && fall_cycles == 1) else begin
            errors++;
            $display("error %0t: ack rose after %0d and fell after %0d cycles, expected 1 and 1",
                     $time, rise_cycles, fall_cycles);
        end
    endtask

    task automatic logic_functions();
        alu_op_pkg::fn_t fns [4];
        string           names [4];
        trit_pkg::trit_t vals [3];
        trit_pkg::word_t x;
        trit_pkg::word_t y;
        fns = '{alu_op_pkg::FN_0, alu_op_pkg::FN_1, alu_op_pkg::FN_2, alu_op_pkg::FN_3};
        names = '{"NOT", "AND", "OR", "XOR"};
        vals = '{trit_pkg::TRIT_NEG, trit_pkg::TRIT_ZERO, trit_pkg::TRIT_POS};
        // All nine trit pairs, one per position
        for (int i = 0; i < trit_pkg::WORD_TRITS; i++) begin
            x[i] = vals[i / 3];
            y[i] = vals[i % 3];
        end
        for (int f = 0; f < 4; f++) begin
            do_op(make_op(alu_op_pkg::UNIT_LOGIC, fns[f]), x, y, names[f]);
            repeat (30)
                do_op(make_op(alu_op_pkg::UNIT_LOGIC, fns[f]),
                      random_word(), random_word(), names[f]);
        end
    endtask

    task automatic add_and_subtract();
        trit_pkg::word_t     ones;
        trit_pkg::word_t     neg_ones;
        trit_pkg::word_t     x;
        trit_pkg::word_t     y;
        alu_op_pkg::opcode_u add_op;
        alu_op_pkg::opcode_u sub_op;
        ones = {trit_pkg::WORD_TRITS{trit_pkg::TRIT_POS}};
        neg_ones = {trit_pkg::WORD_TRITS{trit_pkg::TRIT_NEG}};
        add_op = make_op(alu_op_pkg::UNIT_ARITH, alu_op_pkg::FN_0);
        sub_op = make_op(alu_op_pkg::UNIT_ARITH, alu_op_pkg::FN_1);
        // Carry in every stage
        do_op(add_op, ones, ones, "ADD");
        do_op(sub_op, ones, ones, "SUB");
        do_op(add_op, neg_ones, neg_ones, "ADD");
        do_op(sub_op, neg_ones, neg_ones, "SUB");
        // Largest word plus one wraps to the smallest
        do_op(add_op, ones, trit_pkg::WORD_ONE, "ADD");
        do_op(sub_op, neg_ones, trit_pkg::WORD_ONE, "SUB");
        repeat (40) begin
            x = random_word();
            y = random_word();
            do_op(add_op, x, y, "ADD");
            do_op(sub_op, x, y, "SUB");
        end
    endtask

    task automatic compare_pair(input trit_pkg::word_t x, input trit_pkg::word_t y);
        do_op(make_op(alu_op_pkg::UNIT_ARITH, alu_op_pkg::FN_2), x, y, "LT");
        do_op(make_op(alu_op_pkg::UNIT_ARITH, alu_op_pkg::FN_3), x, y, "EQ");
    endtask

    task automatic comparisons();
        trit_pkg::word_t x;
        trit_pkg::word_t y;
        x = random_word();
        compare_pair(x, x);
        // Only the top trit differs
        y = x;
        y[8] = (x[8] == trit_pkg::TRIT_POS) ? trit_pkg::TRIT_NEG : trit_pkg::TRIT_POS;
        compare_pair(x, y);
        compare_pair(y, x);
        // Only trit 0 differs
        y = x;
        y[0] = (x[0] == trit_pkg::TRIT_POS) ? trit_pkg::TRIT_ZERO : trit_pkg::TRIT_POS;
        compare_pair(x, y);
        compare_pair(y, x);
        // Opposite signs
        x = random_word();
        y = random_word();
        x[8] = trit_pkg::TRIT_POS;
        y[8] = trit_pkg::TRIT_NEG;
        compare_pair(x, y);
        compare_pair(y, x);
        repeat (20)
            compare_pair(random_word(), random_word());
    endtask

    task automatic pass_through();
        alu_op_pkg::fn_t odd_hi;
        alu_op_pkg::fn_t odd_lo;
        odd_hi = {trit_pkg::TRIT_NEG, trit_pkg::TRIT_ZERO};
        odd_lo = {trit_pkg::TRIT_ZERO, trit_pkg::TRIT_NEG};
        do_op(make_op(trit_pkg::TRIT_ZERO, alu_op_pkg::FN_1),
              random_word(), random_word(), "PASS");
        do_op(make_op(alu_op_pkg::UNIT_LOGIC, odd_hi),
              random_word(), random_word(), "LOGIC PASS");
        do_op(make_op(alu_op_pkg::UNIT_ARITH, odd_lo),
              random_word(), random_word(), "ARITH PASS");
    endtask

    task automatic result_hold();
        alu_op_pkg::opcode_u op;
        trit_pkg::word_t     x;
        trit_pkg::word_t     y;
        trit_pkg::word_t     held;
        op = make_op(alu_op_pkg::UNIT_ARITH, alu_op_pkg::FN_0);
        x = random_word();
        y = random_word();
        // Sum that the result register must keep
        held = expected_result(op, x, y);
        do_op(op, x, y, "ADD");
        // Inputs move while req stays low
        repeat (4) begin
            a = random_word();
            b = random_word();
            opcode = make_op(alu_op_pkg::UNIT_LOGIC, alu_op_pkg::FN_3);
            @(posedge clock);
            #1;
            checks++;
            assert (result === held && ack === 1'b0) else begin
                errors++;
                $display("error %0t: result %h did not hold %h, ack=%b", $time, result, held, ack);
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        arst_n = 1'b0;
        req = 1'b0;
        opcode = '0;
        a = '0;
        b = '0;
        errors = 0;
        checks = 0;
        cycle_count = 0;
        lfsr = LFSR_SEED;
        repeat (5) @(posedge clock);
        #1;
        arst_n = 1'b1;
        reset_and_timing();
        logic_functions();
        add_and_subtract();
        comparisons();
        pass_through();
        result_hold();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== src/alu_op_pkg.sv ====
// ALU opcode definitions: opcode size, unit trit values, function codes, opcode union
package alu_op_pkg;

    // Opcode width in trits
    localparam int OP_TRITS = 3;

    // Two-trit function code, high trit first
    typedef trit_pkg::trit_t [1:0] fn_t;

    // Unit trit selects the unit
    // Zero in the unit trit means pass-through of operand a
    localparam trit_pkg::trit_t UNIT_LOGIC = trit_pkg::TRIT_NEG;
    localparam trit_pkg::trit_t UNIT_ARITH = trit_pkg::TRIT_POS;

    // Function codes
    // Logic unit reads them as NOT, AND, OR, XOR
    // Arithmetic unit reads them as ADD, SUB, LT, EQ
    localparam fn_t FN_0 = {trit_pkg::TRIT_ZERO, trit_pkg::TRIT_ZERO};
    localparam fn_t FN_1 = {trit_pkg::TRIT_ZERO, trit_pkg::TRIT_POS};
    localparam fn_t FN_2 = {trit_pkg::TRIT_POS, trit_pkg::TRIT_ZERO};
    localparam fn_t FN_3 = {trit_pkg::TRIT_POS, trit_pkg::TRIT_POS};

    // Opcode word with two views
    // raw is the flat trit array as latched and passed around
    // field splits off the unit trit from the function code
    typedef union packed {
        trit_pkg::trit_t [OP_TRITS-1:0] raw;
        struct packed {
            // Most significant trit
            trit_pkg::trit_t unit;
            fn_t fn;
        } field;
    } opcode_u;

endpackage

// ==== src/alu_result_stage.sv ====
// Result stage: unit select, result register and four-phase req/ack control
`timescale 1ns/10ps

module alu_result_stage (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            req,
    input  trit_pkg::trit_t unit,
    input  trit_pkg::word_t a,
    input  trit_pkg::word_t logic_result,
    input  trit_pkg::word_t arith_result,
    output logic            ack,
    output trit_pkg::word_t result
);

    // Result chosen by the unit trit
    trit_pkg::word_t selected;

    // New request seen while idle
    logic capture;

    // Release once the requester has dropped req
    logic release_ack;

    always_comb begin
        case (unit)
            alu_op_pkg::UNIT_LOGIC: selected = logic_result;
            alu_op_pkg::UNIT_ARITH: selected = arith_result;
            // Zero or illegal unit trit passes a through
            default: selected = a;
        endcase
    end

    // Phase 1 to 2: req high with ack low
    assign capture = req & ~ack;

    // Phase 3 to 4: req low with ack still high
    assign release_ack = ~req & ack;

    // Ack flip-flop
    // Rises one cycle after req is sampled high
    // Falls one cycle after req is sampled low
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else if (capture) begin
            ack <= 1'b1;
        end else if (release_ack) begin
            ack <= 1'b0;
        end
    end

    // Result loads together with the rising ack
    // Holds until the next capture
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (capture) begin
            result <= selected;
        end
    end

endmodule

// ==== src/ternary_alu.sv ====
// Ternary ALU top: logic unit, arithmetic unit and result stage with req/ack handshake
`timescale 1ns/10ps

module ternary_alu (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                req,
    input  alu_op_pkg::opcode_u opcode,
    input  trit_pkg::word_t     a,
    input  trit_pkg::word_t     b,
    output logic                ack,
    output trit_pkg::word_t     result
);

    // Opcode fields
    alu_op_pkg::fn_t fn;
    trit_pkg::trit_t unit;

    // Unit outputs, valid in the same cycle as the operands
    trit_pkg::word_t logic_result;
    trit_pkg::word_t arith_result;

    // Both units see the same function code
    assign fn = opcode.field.fn;

    // Unit trit steers the result stage
    assign unit = opcode.field.unit;

    // NOT, AND, OR, XOR
    trit_logic_unit u_logic (
        .a            (a),
        .b            (b),
        .fn           (fn),
        .logic_result (logic_result)
    );

    // ADD, SUB, LT, EQ
    trit_arith_unit u_arith (
        .a            (a),
        .b            (b),
        .fn           (fn),
        .arith_result (arith_result)
    );

    // One operation in flight, held by the handshake
    alu_result_stage u_result (
        .clock        (clock),
        .arst_n       (arst_n),
        .req          (req),
        .unit         (unit),
        .a            (a),
        .logic_result (logic_result),
        .arith_result (arith_result),
        .ack          (ack),
        .result       (result)
    );

endmodule

// ==== src/trit_arith_unit.sv ====
// Arithmetic unit: ripple adder, subtractor, less-than chain and equality with function select
`timescale 1ns/10ps

module trit_arith_unit (
    input  trit_pkg::word_t a,
    input  trit_pkg::word_t b,
    input  alu_op_pkg::fn_t fn,
    output trit_pkg::word_t arith_result
);

    // Normalized operands and negated b
    trit_pkg::word_t a_n;
    trit_pkg::word_t b_n;
    trit_pkg::word_t b_neg;

    // Ripple outputs
    trit_pkg::word_t add_sum;
    trit_pkg::word_t sub_sum;
    trit_pkg::trit_t add_carry [0:trit_pkg::WORD_TRITS];
    trit_pkg::trit_t sub_carry [0:trit_pkg::WORD_TRITS];

    // Compare chain, index k covers trits k and above
    logic [trit_pkg::WORD_TRITS:0] lt_chain;
    logic [trit_pkg::WORD_TRITS:1] eq_chain;
    logic a_eq_b;

    // Any: saturating sum of two trits
    function automatic trit_pkg::trit_t t_any(
        input trit_pkg::trit_t x,
        input trit_pkg::trit_t y
    );
        if (x == trit_pkg::TRIT_ZERO)
            return y;
        else if (y == trit_pkg::TRIT_ZERO || x == y)
            return x;
        return trit_pkg::TRIT_ZERO;
    endfunction

    // Consensus: common value, else zero
    function automatic trit_pkg::trit_t t_cons(
        input trit_pkg::trit_t x,
        input trit_pkg::trit_t y
    );
        return (x == y) ? x : trit_pkg::TRIT_ZERO;
    endfunction

    // Half adder returns {carry, sum}
    // Sum folds the negated carry into any(x, y) twice
    function automatic logic [2*trit_pkg::TRIT_W-1:0] half_add(
        input trit_pkg::trit_t x,
        input trit_pkg::trit_t y
    );
        trit_pkg::trit_t carry;
        trit_pkg::trit_t carry_neg;
        trit_pkg::trit_t part;
        carry = t_cons(x, y);
        carry_neg = trit_pkg::trit_neg(carry);
        part = t_any(carry_neg, t_any(x, y));
        return {carry, t_any(carry_neg, part)};
    endfunction

    // Full adder from two half adders, carry is any of both carries
    function automatic logic [2*trit_pkg::TRIT_W-1:0] full_add(
        input trit_pkg::trit_t x,
        input trit_pkg::trit_t y,
        input trit_pkg::trit_t cin
    );
        trit_pkg::trit_t c1;
        trit_pkg::trit_t s1;
        trit_pkg::trit_t c2;
        trit_pkg::trit_t s2;
        {c1, s1} = half_add(y, cin);
        {c2, s2} = half_add(x, s1);
        return {t_any(c1, c2), s2};
    endfunction

    // Strict less-than on one trit
    function automatic logic trit_less(
        input trit_pkg::trit_t x,
        input trit_pkg::trit_t y
    );
        return (x == trit_pkg::TRIT_NEG && y != trit_pkg::TRIT_NEG) ||
               (x == trit_pkg::TRIT_ZERO && y == trit_pkg::TRIT_POS);
    endfunction

    assign add_carry[0] = trit_pkg::TRIT_ZERO;
    assign sub_carry[0] = trit_pkg::TRIT_ZERO;

    // Compare starts undecided and equal above the top trit
    assign lt_chain[trit_pkg::WORD_TRITS] = 1'b0;
    assign eq_chain[trit_pkg::WORD_TRITS] = 1'b1;

    for (genvar i = 0; i < trit_pkg::WORD_TRITS; i++) begin : g_stage
        assign a_n[i] = trit_pkg::trit_norm(a[i]);
        assign b_n[i] = trit_pkg::trit_norm(b[i]);
        assign b_neg[i] = trit_pkg::trit_neg(b_n[i]);

        // a+b and a+(-b) ripple in parallel
        // Carry out of trit 8 is dropped so results wrap modulo 3^9
        assign {add_carry[i+1], add_sum[i]} = full_add(a_n[i], b_n[i], add_carry[i]);
        assign {sub_carry[i+1], sub_sum[i]} = full_add(a_n[i], b_neg[i], sub_carry[i]);

        // First differing trit from the top decides
        assign lt_chain[i] = lt_chain[i+1] | (eq_chain[i+1] & trit_less(a_n[i], b_n[i]));
        if (i > 0) begin : g_eq
            assign eq_chain[i] = eq_chain[i+1] & (a_n[i] == b_n[i]);
        end
    end

    // Whole-word equality
    assign a_eq_b = (a_n == b_n);

    always_comb begin
        case (fn)
            alu_op_pkg::FN_0: arith_result = add_sum;
            alu_op_pkg::FN_1: arith_result = sub_sum;
            alu_op_pkg::FN_2: arith_result = lt_chain[0] ? trit_pkg::WORD_ONE : '0;
            alu_op_pkg::FN_3: arith_result = a_eq_b ? trit_pkg::WORD_ONE : '0;
            // Unlisted code passes a through
            default: arith_result = a;
        endcase
    end

endmodule

// ==== src/trit_logic_unit.sv ====
// Trit-wise logic unit: NOT, AND (min), OR (max), XOR with function select
`timescale 1ns/10ps

module trit_logic_unit (
    input  trit_pkg::word_t a,
    input  trit_pkg::word_t b,
    input  alu_op_pkg::fn_t fn,
    output trit_pkg::word_t logic_result
);

    // Minimum of two trits
    function automatic trit_pkg::trit_t trit_min(
        input trit_pkg::trit_t x,
        input trit_pkg::trit_t y
    );
        trit_pkg::trit_t xn;
        trit_pkg::trit_t yn;
        xn = trit_pkg::trit_norm(x);
        yn = trit_pkg::trit_norm(y);
        if (xn == trit_pkg::TRIT_NEG || yn == trit_pkg::TRIT_NEG)
            return trit_pkg::TRIT_NEG;
        else if (xn == trit_pkg::TRIT_ZERO || yn == trit_pkg::TRIT_ZERO)
            return trit_pkg::TRIT_ZERO;
        return trit_pkg::TRIT_POS;
    endfunction

    // Maximum of two trits
    function automatic trit_pkg::trit_t trit_max(
        input trit_pkg::trit_t x,
        input trit_pkg::trit_t y
    );
        trit_pkg::trit_t xn;
        trit_pkg::trit_t yn;
        xn = trit_pkg::trit_norm(x);
        yn = trit_pkg::trit_norm(y);
        if (xn == trit_pkg::TRIT_POS || yn == trit_pkg::TRIT_POS)
            return trit_pkg::TRIT_POS;
        else if (xn == trit_pkg::TRIT_ZERO || yn == trit_pkg::TRIT_ZERO)
            return trit_pkg::TRIT_ZERO;
        return trit_pkg::TRIT_NEG;
    endfunction

    // XOR table
    // Zero input yields the other input
    // Equal nonzero inputs give -1, opposite ones give 0
    function automatic trit_pkg::trit_t trit_xor(
        input trit_pkg::trit_t x,
        input trit_pkg::trit_t y
    );
        trit_pkg::trit_t xn;
        trit_pkg::trit_t yn;
        xn = trit_pkg::trit_norm(x);
        yn = trit_pkg::trit_norm(y);
        if (xn == trit_pkg::TRIT_ZERO)
            return yn;
        else if (yn == trit_pkg::TRIT_ZERO)
            return xn;
        else if (xn == yn)
            return trit_pkg::TRIT_NEG;
        return trit_pkg::TRIT_ZERO;
    endfunction

    // Same function on every trit position
    always_comb begin
        for (int i = 0; i < trit_pkg::WORD_TRITS; i++) begin
            case (fn)
                alu_op_pkg::FN_0: logic_result[i] = trit_pkg::trit_neg(a[i]);
                alu_op_pkg::FN_1: logic_result[i] = trit_min(a[i], b[i]);
                alu_op_pkg::FN_2: logic_result[i] = trit_max(a[i], b[i]);
                alu_op_pkg::FN_3: logic_result[i] = trit_xor(a[i], b[i]);
                // Unlisted code passes a through
                default: logic_result[i] = a[i];
            endcase
        end
    end

endmodule

// ==== src/trit_pkg.sv ====
// Balanced-ternary number system: trit codes, word size, trit and word types, trit helpers
package trit_pkg;

    // Two bits carry one trit
    localparam int TRIT_W = 2;

    // Data word size in trits and in bits
    localparam int WORD_TRITS = 9;
    localparam int WORD_W = WORD_TRITS * TRIT_W;

    typedef logic [TRIT_W-1:0] trit_t;

    // Trit 0 is the least significant
    typedef trit_t [WORD_TRITS-1:0] word_t;

    // Legal trit codes
    localparam trit_t TRIT_NEG = 2'b11;
    localparam trit_t TRIT_ZERO = 2'b00;
    localparam trit_t TRIT_POS = 2'b01;

    // Word holding +1 in trit 0, used as the true flag
    localparam word_t WORD_ONE = {{(WORD_W - TRIT_W){1'b0}}, TRIT_POS};

    // Code 2'b10 is read as zero
    function automatic trit_t trit_norm(input trit_t t);
        return (t == 2'b10) ? TRIT_ZERO : t;
    endfunction

    // Trit negation, illegal code gives zero
    function automatic trit_t trit_neg(input trit_t t);
        case (t)
            TRIT_NEG: return TRIT_POS;
            TRIT_POS: return TRIT_NEG;
            default: return TRIT_ZERO;
        endcase
    endfunction

endpackage
